// ==== src/periph_consts.svh ====
/*
 * Timing and width constants for the peripheral I/O block.
 * Include wherever pad scan timing or audio sample widths are needed.
 */

`ifndef ICS32_PERIPH_CONSTS_SVH
`define ICS32_PERIPH_CONSTS_SVH

// Buttons per player, one serial word
`define PAD_BUTTONS 12

// clk_2x cycles per pad_clk half period and per latch pulse
`define PAD_HALF_BIT 4

// Cycles from one scan start to the next
`define PAD_SCAN_PERIOD 256

// Signed PCM sample width
`define PCM_WIDTH 16

`endif

// ==== src/pad_pkg.sv ====
/*
 * Types shared by the game pad reader and the mock pad.
 * Button vectors use 1 for pressed; the wire level is inverted.
 */

`include "periph_consts.svh"

package pad_pkg;

    // Bit i is button i, 1 means pressed
    typedef logic [`PAD_BUTTONS-1:0] pad_buttons_t;

    // Scan sequence: wait for period, latch, then clock out each bit
    typedef enum logic [1:0] {
        SCAN_IDLE     = 2'd0,
        SCAN_LATCH    = 2'd1,
        SCAN_CLK_LOW  = 2'd2,
        SCAN_CLK_HIGH = 2'd3
    } pad_scan_state_t;

endpackage

// ==== src/audio_pkg.sv ====
/*
 * Types for the PCM to PDM audio path.
 */

`include "periph_consts.svh"

package audio_pkg;

    // Signed two's complement input sample
    typedef logic signed [`PCM_WIDTH-1:0] pcm_sample_t;

    // Accumulator with one carry bit above the sample
    typedef logic [`PCM_WIDTH:0] pdm_acc_t;

endpackage

// ==== src/gamepad_reader.sv ====
/*
 * Serial game pad scanner for two players.
 * Pulses pad_latch, clocks in twelve bits per player on pad_clk and
 * publishes both button vectors with a one-cycle pad_valid strobe.
 */

`timescale 1ns/10ps

`include "periph_consts.svh"

module gamepad_reader (
    input  logic                 clk_2x,
    input  logic                 rst_n,
    input  logic [1:0]           pad_data,
    output logic                 pad_latch,
    output logic                 pad_clk,
    output pad_pkg::pad_buttons_t p1_buttons,
    output pad_pkg::pad_buttons_t p2_buttons,
    output logic                 pad_valid
);
    import pad_pkg::*;

    localparam int PERIOD_W = $clog2(`PAD_SCAN_PERIOD);
    localparam int PHASE_W  = $clog2(`PAD_HALF_BIT);
    localparam int BIT_W    = $clog2(`PAD_BUTTONS);

    pad_scan_state_t state;

    logic [PERIOD_W-1:0] period_cnt;
    logic [PHASE_W-1:0]  phase_cnt;
    logic [BIT_W-1:0]    bit_cnt;
    logic                period_done;
    logic                phase_done;
    logic                last_bit;

    logic [1:0]   data_meta;
    logic [1:0]   data_sync;
    pad_buttons_t p1_shift;
    pad_buttons_t p2_shift;

    assign period_done = (period_cnt == PERIOD_W'(`PAD_SCAN_PERIOD - 1));
    assign phase_done  = (phase_cnt == PHASE_W'(`PAD_HALF_BIT - 1));
    assign last_bit    = (bit_cnt == BIT_W'(`PAD_BUTTONS - 1));

    assign pad_latch = (state == SCAN_LATCH);
    assign pad_clk   = (state == SCAN_CLK_HIGH);

    // Two-flop synchronizer on both data lines
    always_ff @(posedge clk_2x) begin
        data_meta <= pad_data;
        data_sync <= data_meta;
    end

    // Free-running scan period
    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_done ? '0 : period_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            state      <= SCAN_IDLE;
            phase_cnt  <= '0;
            bit_cnt    <= '0;
            pad_valid  <= 1'b0;
            p1_buttons <= '0;
            p2_buttons <= '0;
        end else begin
            pad_valid <= 1'b0;
            phase_cnt <= phase_done ? '0 : phase_cnt + 1'b1;

            case (state)
                SCAN_IDLE: begin
                    phase_cnt <= '0;
                    if (period_done) begin
                        state <= SCAN_LATCH;
                    end
                end
                SCAN_LATCH: begin
                    if (phase_done) begin
                        bit_cnt <= '0;
                        state   <= SCAN_CLK_LOW;
                    end
                end
                SCAN_CLK_LOW: begin
                    if (phase_done) begin
                        state <= SCAN_CLK_HIGH;
                    end
                end
                SCAN_CLK_HIGH: begin
                    if (phase_done) begin
                        if (last_bit) begin
                            // Publish both players once the full word is in
                            p1_buttons <= p1_shift;
                            p2_buttons <= p2_shift;
                            pad_valid  <= 1'b1;
                            state      <= SCAN_IDLE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            state   <= SCAN_CLK_LOW;
                        end
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    // Sample on the last low cycle
    // A pressed button pulls its line low
    always_ff @(posedge clk_2x) begin
        if (state == SCAN_CLK_LOW && phase_done) begin
            p1_shift <= {~data_sync[0], p1_shift[`PAD_BUTTONS-1:1]};
            p2_shift <= {~data_sync[1], p2_shift[`PAD_BUTTONS-1:1]};
        end
    end

    // Whole scan fits inside one period
    a_scan_within_period: assert property (
        @(posedge clk_2x) disable iff (!rst_n) period_done |-> state == SCAN_IDLE);

    a_valid_single_pulse: assert property (
        @(posedge clk_2x) disable iff (!rst_n) pad_valid |=> !pad_valid);

endmodule

// ==== src/mock_gamepad.sv ====
/*
 * Stand-in for a serial pad shift register, fed from parallel buttons.
 * Loads while pad_latch is high and steps one bit per pad_clk rise.
 */

`timescale 1ns/10ps

`include "periph_consts.svh"

module mock_gamepad (
    input  logic                  clk_2x,
    input  logic                  rst_n,
    input  logic                  pad_latch,
    input  logic                  pad_clk,
    input  pad_pkg::pad_buttons_t pad_btn,
    output logic                  pad_out
);
    import pad_pkg::*;

    pad_buttons_t shift_reg;
    logic         pad_clk_q;
    logic         pad_clk_rise;

    assign pad_clk_rise = pad_clk && !pad_clk_q;

    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            pad_clk_q <= 1'b0;
            shift_reg <= '0;
            pad_out   <= 1'b1;
        end else begin
            pad_clk_q <= pad_clk;

            if (pad_latch) begin
                shift_reg <= pad_btn;
            end else if (pad_clk_rise) begin
                // Zeros shift in, so the line reads released past bit 11
                shift_reg <= {1'b0, shift_reg[`PAD_BUTTONS-1:1]};
            end

            // Active low on the wire
            pad_out <= ~shift_reg[0];
        end
    end

endmodule

// ==== src/pdm_dac.sv ====
/*
 * First-order sigma-delta DAC.
 * Converts a signed PCM sample to a PDM bit stream whose density of ones
 * tracks the sample in offset binary.
 */

`timescale 1ns/10ps

`include "periph_consts.svh"

module pdm_dac (
    input  logic                   clk_2x,
    input  logic                   rst_n,
    input  audio_pkg::pcm_sample_t pcm_in,
    input  logic                   pcm_valid,
    output logic                   pdm_out
);
    import audio_pkg::*;

    logic [`PCM_WIDTH-1:0] sample_q;
    pdm_acc_t              acc;

    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            sample_q <= '0;
            acc      <= '0;
            pdm_out  <= 1'b0;
        end else begin
            // Flip the sign bit for offset binary
            if (pcm_valid) begin
                sample_q <= {~pcm_in[`PCM_WIDTH-1], pcm_in[`PCM_WIDTH-2:0]};
            end

            // Carry out of the low bits is the next PDM bit
            acc     <= {1'b0, acc[`PCM_WIDTH-1:0]} + {1'b0, sample_q};
            pdm_out <= acc[`PCM_WIDTH];
        end
    end

    a_pdm_known: assert property (
        @(posedge clk_2x) disable iff (!rst_n) !$isunknown(pdm_out));

endmodule

// ==== src/ics32_periph_io.sv ====
/*
 * Board-side peripheral I/O: game pad scan and stereo PDM audio.
 * GAMEPAD_PMOD = 1 reads both pads from external data lines; 0 uses the
 * breakout buttons through an on-chip mock pad for player 1.
 */

`timescale 1ns/10ps

`include "periph_consts.svh"

module ics32_periph_io #(
    parameter [0:0] GAMEPAD_PMOD = 0
) (
    input  logic                    clk_2x,
    input  logic                    rst_n,

    input  logic [3:0]              btn,
    input  logic [1:0]              pad_data_ext,
    output logic                    pad_latch,
    output logic                    pad_clk,
    output logic [`PAD_BUTTONS-1:0] pad_p1,
    output logic [`PAD_BUTTONS-1:0] pad_p2,
    output logic                    pad_valid,

    input  logic [`PCM_WIDTH-1:0]   pcm_l,
    input  logic [`PCM_WIDTH-1:0]   pcm_r,
    input  logic                    pcm_valid,
    output logic                    pdm_l,
    output logic                    pdm_r
);
    import pad_pkg::*;

    logic [1:0] pad_data;

    generate
        if (GAMEPAD_PMOD) begin : g_pad_pmod
            assign pad_data = pad_data_ext;
        end else begin : g_pad_mock
            pad_buttons_t pad_btn;

            // Breakout board covers only a few player 1 buttons
            assign pad_btn = {{(`PAD_BUTTONS - 8){1'b0}}, btn[0], btn[2], 5'b0, btn[1]};

            // Fourth button holds the whole P2 line low
            assign pad_data[1] = ~btn[3];

            mock_gamepad mock_gamepad (
                .clk_2x   (clk_2x),
                .rst_n    (rst_n),
                .pad_latch(pad_latch),
                .pad_clk  (pad_clk),
                .pad_btn  (pad_btn),
                .pad_out  (pad_data[0])
            );
        end
    endgenerate

    gamepad_reader gamepad_reader (
        .clk_2x    (clk_2x),
        .rst_n     (rst_n),
        .pad_data  (pad_data),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .p1_buttons(pad_p1),
        .p2_buttons(pad_p2),
        .pad_valid (pad_valid)
    );

    // Stereo audio
    pdm_dac pdm_dac_l (
        .clk_2x   (clk_2x),
        .rst_n    (rst_n),
        .pcm_in   (pcm_l),
        .pcm_valid(pcm_valid),
        .pdm_out  (pdm_l)
    );

    pdm_dac pdm_dac_r (
        .clk_2x   (clk_2x),
        .rst_n    (rst_n),
        .pcm_in   (pcm_r),
        .pcm_valid(pcm_valid),
        .pdm_out  (pdm_r)
    );

endmodule

// ==== tests/tb_ics32_periph_io.sv ====
/*
 * Testbench for the peripheral I/O top level in breakout mode.
 * Applies a table of button and PCM entries, checks both pad vectors
 * after a full scan and the PDM density of each channel.
 */

`timescale 1ns/10ps

`include "periph_consts.svh"

module tb_ics32_periph_io;
    import pad_pkg::*;
    import audio_pkg::*;

    localparam int NUM_ENTRIES     = 8;
    localparam int DENSITY_CYCLES  = 1024;
    localparam int WAIT_LIMIT      = 2 * `PAD_SCAN_PERIOD;
    localparam int WATCHDOG_CYCLES = NUM_ENTRIES * (3 * `PAD_SCAN_PERIOD + 1100);

    logic         clk_2x;
    logic         rst_n;
    logic [3:0]   btn;
    logic [1:0]   pad_data_ext;
    logic         pad_latch;
    logic         pad_clk;
    pad_buttons_t pad_p1;
    pad_buttons_t pad_p2;
    logic         pad_valid;
    pcm_sample_t  pcm_l;
    pcm_sample_t  pcm_r;
    logic         pcm_valid;
    logic         pdm_l;
    logic         pdm_r;

    // Stimulus table
    string        test_name [NUM_ENTRIES];
    logic [3:0]   test_btn  [NUM_ENTRIES];
    pcm_sample_t  test_pcm_l[NUM_ENTRIES];
    pcm_sample_t  test_pcm_r[NUM_ENTRIES];

    int           mismatch_count;
    int           failure_count;
    logic [31:0]  lfsr;

    // Scan shape monitor state
    logic         latch_q;
    logic         clk_q;
    int           latch_count;
    int           clk_pulses;

    ics32_periph_io #(.GAMEPAD_PMOD(1'b0)) DUT (
        .clk_2x      (clk_2x),
        .rst_n       (rst_n),
        .btn         (btn),
        .pad_data_ext(pad_data_ext),
        .pad_latch   (pad_latch),
        .pad_clk     (pad_clk),
        .pad_p1      (pad_p1),
        .pad_p2      (pad_p2),
        .pad_valid   (pad_valid),
        .pcm_l       (pcm_l),
        .pcm_r       (pcm_r),
        .pcm_valid   (pcm_valid),
        .pdm_l       (pdm_l),
        .pdm_r       (pdm_r)
    );

    initial begin
        clk_2x = 1'b0;
        forever #50 clk_2x = ~clk_2x;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_2x);
        $display("ERROR: run did not finish within %0d cycles, stopping", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic check_pad(input string name, input pad_buttons_t expected,
                             input pad_buttons_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %03h, actual %03h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_pulses(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
            mismatch_count++;
        end
    endtask

    // Ideal count is cycles * (sample + half scale) / full scale, tolerance of one
    task automatic check_density(input string name, input pcm_sample_t sample, input int ones);
        int offset;
        int scaled_err;
        offset     = int'(sample) + (1 << (`PCM_WIDTH - 1));
        scaled_err = ones * (1 << `PCM_WIDTH) - DENSITY_CYCLES * offset;
        if (scaled_err > (1 << `PCM_WIDTH) || scaled_err < -(1 << `PCM_WIDTH)) begin
            $display("MISMATCH %s: expected %0.2f, actual %0d", name,
                     real'(DENSITY_CYCLES * offset) / real'(1 << `PCM_WIDTH), ones);
            mismatch_count++;
        end
    endtask

    task automatic fill_table();
        logic [31:0] rnd;
        test_name[0] = "full_scale";
        test_btn[0]  = 4'b0000;
        test_pcm_l[0] = 16'sh8000;
        test_pcm_r[0] = 16'sh7fff;
        test_name[1] = "btn1_midscale";
        test_btn[1]  = 4'b0010;
        test_pcm_l[1] = 16'sh0000;
        test_pcm_r[1] = 16'sh0000;
        test_name[2] = "btn2_p2";
        test_btn[2]  = 4'b1100;
        test_pcm_l[2] = 16'sh4000;
        test_pcm_r[2] = 16'shc000;
        test_name[3] = "btn0_swapped";
        test_btn[3]  = 4'b0001;
        test_pcm_l[3] = 16'sh7fff;
        test_pcm_r[3] = 16'sh8000;
        test_name[4] = "all_buttons";
        test_btn[4]  = 4'b1111;
        test_pcm_l[4] = 16'sh1234;
        test_pcm_r[4] = 16'shedcc;
        test_name[5] = "p2_only";
        test_btn[5]  = 4'b1000;
        test_pcm_l[5] = 16'shffff;
        test_pcm_r[5] = 16'sh0001;
        for (int i = 6; i < NUM_ENTRIES; i++) begin
            test_name[i] = $sformatf("lfsr_%0d", i - 6);
            take_bits(4, rnd);
            test_btn[i] = rnd[3:0];
            take_bits(`PCM_WIDTH, rnd);
            test_pcm_l[i] = rnd[`PCM_WIDTH-1:0];
            take_bits(`PCM_WIDTH, rnd);
            test_pcm_r[i] = rnd[`PCM_WIDTH-1:0];
        end
    endtask

    // Returns on the negedge where pad_valid is seen high
    task automatic wait_pad_valid(input string name, input bit idle_checks);
        int cycles;
        cycles = 0;
        @(negedge clk_2x);
        while (!pad_valid && cycles < WAIT_LIMIT) begin
            if (idle_checks) begin
                check_pad({name, " pad_p1"}, '0, pad_p1);
                check_pad({name, " pad_p2"}, '0, pad_p2);
                check_level({name, " pdm_l"}, 1'b0, pdm_l);
                check_level({name, " pdm_r"}, 1'b0, pdm_r);
            end
            @(negedge clk_2x);
            cycles++;
        end
        if (!pad_valid) begin
            $display("ERROR: %s: pad_valid did not arrive within %0d cycles", name, WAIT_LIMIT);
            failure_count++;
        end
    endtask

    // One latch then twelve clock pulses per scan, never overlapping
    always @(negedge clk_2x) begin
        if (!rst_n) begin
            latch_q     = 1'b0;
            clk_q       = 1'b0;
            latch_count = 0;
            clk_pulses  = 0;
        end else begin
            if (pad_latch && pad_clk) begin
                $display("ERROR: pad_latch and pad_clk high together at %0t", $time);
                failure_count++;
            end
            if (pad_latch && !latch_q) begin
                latch_count++;
                clk_pulses = 0;
            end
            if (pad_clk && !clk_q) begin
                clk_pulses++;
            end
            if (pad_valid) begin
                check_pulses("scan latch pulses", 1, latch_count);
                check_pulses("scan pad_clk pulses", `PAD_BUTTONS, clk_pulses);
                latch_count = 0;
            end
            latch_q = pad_latch;
            clk_q   = pad_clk;
        end
    end

    initial begin
        pad_buttons_t exp_p1;
        pad_buttons_t exp_p2;
        int           ones_l;
        int           ones_r;

        mismatch_count = 0;
        failure_count  = 0;
        lfsr           = 32'h4671;
        rst_n          = 1'b0;
        btn            = '0;
        pad_data_ext   = 2'b11;
        pcm_l          = '0;
        pcm_r          = '0;
        pcm_valid      = 1'b0;
        fill_table();

        repeat (5) @(posedge clk_2x);
        rst_n <= 1'b1;

        @(negedge clk_2x);
        check_level("reset pad_latch", 1'b0, pad_latch);
        check_level("reset pad_clk", 1'b0, pad_clk);
        check_level("reset pad_valid", 1'b0, pad_valid);
        wait_pad_valid("reset", 1'b1);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(posedge clk_2x);
            btn   <= test_btn[i];
            pcm_l <= test_pcm_l[i];
            pcm_r <= test_pcm_r[i];

            // First scan may have latched the old buttons
            wait_pad_valid(test_name[i], 1'b0);
            wait_pad_valid(test_name[i], 1'b0);
            exp_p1    = '0;
            exp_p1[0] = test_btn[i][1];
            exp_p1[6] = test_btn[i][2];
            exp_p1[7] = test_btn[i][0];
            exp_p2    = test_btn[i][3] ? '1 : '0;
            check_pad({test_name[i], " pad_p1"}, exp_p1, pad_p1);
            check_pad({test_name[i], " pad_p2"}, exp_p2, pad_p2);

            @(posedge clk_2x);
            pcm_valid <= 1'b1;
            @(posedge clk_2x);
            pcm_valid <= 1'b0;
            // Sample register, accumulator and output flop
            repeat (3) @(posedge clk_2x);
            ones_l = 0;
            ones_r = 0;
            repeat (DENSITY_CYCLES) begin
                @(negedge clk_2x);
                ones_l += int'(pdm_l);
                ones_r += int'(pdm_r);
            end
            check_density({test_name[i], " pdm_l"}, test_pcm_l[i], ones_l);
            check_density({test_name[i], " pdm_r"}, test_pcm_r[i], ones_r);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== ics32_periph_io.f ====
+incdir+src
src/pad_pkg.sv
src/audio_pkg.sv
src/gamepad_reader.sv
src/mock_gamepad.sv
src/pdm_dac.sv
src/ics32_periph_io.sv
tests/tb_ics32_periph_io.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ics32_periph_io
FILELIST  = ics32_periph_io.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
